// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_padframe
FILELIST = all.f
PASS_MSG = All tests passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+.
pad_pkg.sv
cfg_bus_if.sv
boot_ctrl.sv
cfg_decode.sv
pad_cfg_regs.sv
pad_mux.sv
padframe_top.sv
tb_padframe.sv

// ==== boot_ctrl.sv ====
//////////////////////////////
// power-on reset synchronizer for the reference clock
// and one-shot capture of the boot pins at reset release
//////////////////////////////

`default_nettype none

`include "pad_defines.svh"

module boot_ctrl
  import pad_pkg::*;
(
  input  wire logic         ref_clk_i,
  input  wire logic         rst_n_i,
  input  wire logic [1:0]   boot_mode_i,
  input  wire logic         secure_boot_i,
  output logic              rst_sync_n_o,
  output boot_status_t      boot_status_o
);

  logic [1:0]   sync_q;
  logic         captured_q;
  boot_status_t boot_status_q;

  // async assert, release after two edges
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_sync_n_o = sync_q[1];

  // pins sampled once on the first cycle out of reset
  always_ff @(posedge ref_clk_i or negedge rst_sync_n_o) begin
    if (!rst_sync_n_o) begin
      captured_q    <= 1'b0;
      boot_status_q <= '0;
    end else if (!captured_q) begin
      captured_q                <= 1'b1;
      boot_status_q.boot_mode   <= boot_mode_i;
      boot_status_q.secure_boot <= secure_boot_i;
    end
  end

  assign boot_status_o = boot_status_q;

endmodule

`default_nettype wire

// ==== cfg_bus_if.sv ====
//////////////////////////////
// decoded command from the request decoder to the register file
// cmd_valid is a one-cycle strobe, the rest is valid with it
//////////////////////////////

`default_nettype none

`include "pad_defines.svh"

interface cfg_bus_if
  import pad_pkg::*;
();

  logic                   cmd_valid;
  cfg_op_e                cmd_op;
  pad_idx_t               cmd_pad;
  logic [`PAD_FUNC_W-1:0] cmd_wdata;

  modport decoder (
    output cmd_valid,
    output cmd_op,
    output cmd_pad,
    output cmd_wdata
  );

  modport regs (
    input cmd_valid,
    input cmd_op,
    input cmd_pad,
    input cmd_wdata
  );

endinterface

`default_nettype wire

// ==== cfg_decode.sv ====
//////////////////////////////
// decode stage of the register port
// classifies each request against the address map and
// hands one command per request to the register file
//////////////////////////////

`default_nettype none

`include "pad_defines.svh"

module cfg_decode
  import pad_pkg::*;
(
  input  wire logic                   ref_clk_i,
  input  wire logic                   rst_n_i,
  input  wire logic                   req_valid_i,
  input  wire logic                   req_write_i,
  input  wire logic [`REG_ADDR_W-1:0] req_addr_i,
  input  wire reg_data_t              req_wdata_i,
  cfg_bus_if.decoder                  bus
);

  cfg_op_e op_d;

  logic                   valid_q;
  cfg_op_e                op_q;
  pad_idx_t               pad_q;
  logic [`PAD_FUNC_W-1:0] wdata_q;

  // address map check
  always_comb begin
    if (!req_valid_i) begin
      op_d = OP_NONE;
    end else if (req_addr_i < `REG_ADDR_W'(`PAD_NUM_MUXED)) begin
      op_d = req_write_i ? OP_WRITE_PAD : OP_READ_PAD;
    end else if (req_addr_i == `REG_STATUS_ADDR) begin
      // status is read-only
      op_d = req_write_i ? OP_ERROR : OP_READ_STATUS;
    end else begin
      op_d = OP_ERROR;
    end
  end

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      op_q    <= OP_NONE;
    end else begin
      valid_q <= req_valid_i;
      op_q    <= op_d;
    end
  end

  // payload, only looked at with valid_q
  always_ff @(posedge ref_clk_i) begin
    pad_q   <= pad_idx_t'(req_addr_i);
    wdata_q <= req_wdata_i[`PAD_FUNC_W-1:0];
  end

  assign bus.cmd_valid = valid_q;
  assign bus.cmd_op    = op_q;
  assign bus.cmd_pad   = pad_q;
  assign bus.cmd_wdata = wdata_q;

endmodule

`default_nettype wire

// ==== pad_cfg_regs.sv ====
//////////////////////////////
// execute stage, pad select registers and boot status
// one registered response per command, never stalls
//////////////////////////////

`default_nettype none

`include "pad_defines.svh"

module pad_cfg_regs
  import pad_pkg::*;
(
  input  wire logic         ref_clk_i,
  input  wire logic         rst_n_i,
  cfg_bus_if.regs           bus,
  input  wire boot_status_t boot_status_i,
  output pad_func_e         pad_sel_o [`PAD_NUM_MUXED],
  output logic              rsp_valid_o,
  output reg_data_t         rsp_rdata_o,
  output logic              rsp_error_o
);

  pad_func_e pad_sel_q [`PAD_NUM_MUXED];
  reg_data_t rdata_d;
  logic      error_d;
  logic      wr_en;

  assign wr_en = bus.cmd_valid && (bus.cmd_op == OP_WRITE_PAD);

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `PAD_NUM_MUXED; i++) begin
        pad_sel_q[i] <= FUNC_GPIO;
      end
    end else if (wr_en) begin
      pad_sel_q[bus.cmd_pad] <= pad_func_e'(bus.cmd_wdata);
    end
  end

  // read data, zero for writes and errors
  always_comb begin
    rdata_d = '0;
    error_d = 1'b0;
    if (bus.cmd_valid) begin
      case (bus.cmd_op)
        OP_READ_PAD: begin
          rdata_d[`PAD_FUNC_W-1:0] = pad_sel_q[bus.cmd_pad];
        end
        OP_READ_STATUS: begin
          rdata_d = reg_data_t'(boot_status_i);
        end
        OP_ERROR: begin
          error_d = 1'b1;
        end
        default: begin
          rdata_d = '0;
        end
      endcase
    end
  end

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
      rsp_error_o <= 1'b0;
    end else begin
      rsp_valid_o <= bus.cmd_valid;
      rsp_error_o <= error_d;
    end
  end

  always_ff @(posedge ref_clk_i) begin
    rsp_rdata_o <= rdata_d;
  end

  assign pad_sel_o = pad_sel_q;

endmodule

`default_nettype wire

// ==== pad_defines.svh ====
//////////////////////////////
// pad count, register widths and address map
// of the pad control block, included by every RTL file
//////////////////////////////

`ifndef PAD_DEFINES_SVH
`define PAD_DEFINES_SVH

// multiplexed pads
`define PAD_NUM_MUXED 22

// function select width, four functions
`define PAD_FUNC_W 2

// register port
`define REG_ADDR_W 8
`define REG_DATA_W 32

// word 0 to PAD_NUM_MUXED-1 are the pad selects
`define REG_STATUS_ADDR 8'h20

`endif

// ==== pad_mux.sv ====
//////////////////////////////
// result stage, combinational pad routing
// outputs go from the owning function to the pad, the pad
// input goes back to the owner only
//////////////////////////////

`default_nettype none

`include "pad_defines.svh"

module pad_mux
  import pad_pkg::*;
(
  input  wire pad_func_e pad_sel_i [`PAD_NUM_MUXED],
  input  wire pad_vec_t  gpio_out_i,
  input  wire pad_vec_t  gpio_oe_i,
  output pad_vec_t       gpio_in_o,
  input  wire pad_vec_t  spi_out_i,
  input  wire pad_vec_t  spi_oe_i,
  output pad_vec_t       spi_in_o,
  input  wire pad_vec_t  i2c_out_i,
  input  wire pad_vec_t  i2c_oe_i,
  output pad_vec_t       i2c_in_o,
  input  wire pad_vec_t  uart_out_i,
  input  wire pad_vec_t  uart_oe_i,
  output pad_vec_t       uart_in_o,
  input  wire pad_vec_t  pad_in_i,
  output pad_vec_t       pad_out_o,
  output pad_vec_t       pad_oe_o
);

  always_comb begin
    pad_out_o = '0;
    pad_oe_o  = '0;
    gpio_in_o = '0;
    spi_in_o  = '0;
    i2c_in_o  = '0;
    uart_in_o = '0;
    for (int i = 0; i < `PAD_NUM_MUXED; i++) begin
      case (pad_sel_i[i])
        FUNC_SPI: begin
          pad_out_o[i] = spi_out_i[i];
          pad_oe_o[i]  = spi_oe_i[i];
        end
        FUNC_I2C: begin
          pad_out_o[i] = i2c_out_i[i];
          pad_oe_o[i]  = i2c_oe_i[i];
        end
        FUNC_UART: begin
          pad_out_o[i] = uart_out_i[i];
          pad_oe_o[i]  = uart_oe_i[i];
        end
        default: begin
          pad_out_o[i] = gpio_out_i[i];
          pad_oe_o[i]  = gpio_oe_i[i];
        end
      endcase
      // non-owners see zero
      gpio_in_o[i] = pad_in_i[i] & (pad_sel_i[i] == FUNC_GPIO);
      spi_in_o[i]  = pad_in_i[i] & (pad_sel_i[i] == FUNC_SPI);
      i2c_in_o[i]  = pad_in_i[i] & (pad_sel_i[i] == FUNC_I2C);
      uart_in_o[i] = pad_in_i[i] & (pad_sel_i[i] == FUNC_UART);
    end
  end

endmodule

`default_nettype wire

// ==== pad_pkg.sv ====
//////////////////////////////
// types shared by the pad control block
// imported by every RTL module and the config interface
//////////////////////////////

`default_nettype none

`include "pad_defines.svh"

package pad_pkg;

  // function that owns a pad
  typedef enum logic [`PAD_FUNC_W-1:0] {
    FUNC_GPIO = 2'd0,
    FUNC_SPI  = 2'd1,
    FUNC_I2C  = 2'd2,
    FUNC_UART = 2'd3
  } pad_func_e;

  // decoded register command, five values need three bits
  typedef enum logic [2:0] {
    OP_NONE,
    OP_READ_PAD,
    OP_WRITE_PAD,
    OP_READ_STATUS,
    OP_ERROR
  } cfg_op_e;

  // secure_boot on top so bits 1:0 map to boot_mode
  typedef struct packed {
    logic       secure_boot;
    logic [1:0] boot_mode;
  } boot_status_t;

  typedef logic [`PAD_NUM_MUXED-1:0] pad_vec_t;
  typedef logic [4:0]                pad_idx_t;
  typedef logic [`REG_DATA_W-1:0]    reg_data_t;

endpackage

`default_nettype wire

// ==== padframe_top.sv ====
//////////////////////////////
// pad control block top, reference clock domain
// register port in, pad and function vectors routed through
//////////////////////////////

`default_nettype none

`include "pad_defines.svh"

module padframe_top
  import pad_pkg::*;
(
  input  wire logic                   ref_clk_i,
  input  wire logic                   rst_n_i,
  input  wire logic [1:0]             boot_mode_i,
  input  wire logic                   secure_boot_i,
  // register port
  input  wire logic                   req_valid_i,
  input  wire logic                   req_write_i,
  input  wire logic [`REG_ADDR_W-1:0] req_addr_i,
  input  wire reg_data_t              req_wdata_i,
  output logic                        rsp_valid_o,
  output reg_data_t                   rsp_rdata_o,
  output logic                        rsp_error_o,
  // peripheral functions
  input  wire pad_vec_t               gpio_out_i,
  input  wire pad_vec_t               gpio_oe_i,
  output pad_vec_t                    gpio_in_o,
  input  wire pad_vec_t               spi_out_i,
  input  wire pad_vec_t               spi_oe_i,
  output pad_vec_t                    spi_in_o,
  input  wire pad_vec_t               i2c_out_i,
  input  wire pad_vec_t               i2c_oe_i,
  output pad_vec_t                    i2c_in_o,
  input  wire pad_vec_t               uart_out_i,
  input  wire pad_vec_t               uart_oe_i,
  output pad_vec_t                    uart_in_o,
  // pads
  input  wire pad_vec_t               pad_in_i,
  output pad_vec_t                    pad_out_o,
  output pad_vec_t                    pad_oe_o
);

  logic         rst_sync_n;
  boot_status_t boot_status;
  pad_func_e    pad_sel [`PAD_NUM_MUXED];

  cfg_bus_if cfg_bus ();

  //////////////////////////////
  // reset and boot capture
  //////////////////////////////

  boot_ctrl i_boot_ctrl (
    .ref_clk_i     ( ref_clk_i     ),
    .rst_n_i       ( rst_n_i       ),
    .boot_mode_i   ( boot_mode_i   ),
    .secure_boot_i ( secure_boot_i ),
    .rst_sync_n_o  ( rst_sync_n    ),
    .boot_status_o ( boot_status   )
  );

  //////////////////////////////
  // register pipeline
  //////////////////////////////

  cfg_decode i_cfg_decode (
    .ref_clk_i   ( ref_clk_i   ),
    .rst_n_i     ( rst_sync_n  ),
    .req_valid_i ( req_valid_i ),
    .req_write_i ( req_write_i ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .bus         ( cfg_bus     )
  );

  pad_cfg_regs i_pad_cfg_regs (
    .ref_clk_i     ( ref_clk_i   ),
    .rst_n_i       ( rst_sync_n  ),
    .bus           ( cfg_bus     ),
    .boot_status_i ( boot_status ),
    .pad_sel_o     ( pad_sel     ),
    .rsp_valid_o   ( rsp_valid_o ),
    .rsp_rdata_o   ( rsp_rdata_o ),
    .rsp_error_o   ( rsp_error_o )
  );

  //////////////////////////////
  // pad routing
  //////////////////////////////

  pad_mux i_pad_mux (
    .pad_sel_i  ( pad_sel    ),
    .gpio_out_i ( gpio_out_i ),
    .gpio_oe_i  ( gpio_oe_i  ),
    .gpio_in_o  ( gpio_in_o  ),
    .spi_out_i  ( spi_out_i  ),
    .spi_oe_i   ( spi_oe_i   ),
    .spi_in_o   ( spi_in_o   ),
    .i2c_out_i  ( i2c_out_i  ),
    .i2c_oe_i   ( i2c_oe_i   ),
    .i2c_in_o   ( i2c_in_o   ),
    .uart_out_i ( uart_out_i ),
    .uart_oe_i  ( uart_oe_i  ),
    .uart_in_o  ( uart_in_o  ),
    .pad_in_i   ( pad_in_i   ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   )
  );

endmodule

`default_nettype wire

// ==== tb_padframe.sv ====
//////////////////////////////
// testbench for the pad control block, random register traffic
// and pad vectors from an LFSR, checked against a local model
//////////////////////////////

`default_nettype none

`include "pad_defines.svh"

module tb_padframe
  import pad_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam int NUM_REQ    = 22 + 2 + 80 + 8 * 22 + 32 + 1 + 22;
  localparam int NUM_ROUTE  = 1 + 8 * 4;

  logic ref_clk = 1'b0;
  logic rst_n;
  logic [1:0] boot_mode;
  logic secure_boot;
  logic req_valid;
  logic req_write;
  logic [`REG_ADDR_W-1:0] req_addr;
  reg_data_t req_wdata;
  logic rsp_valid;
  reg_data_t rsp_rdata;
  logic rsp_error;
  pad_vec_t gpio_out, gpio_oe, gpio_in, spi_out, spi_oe, spi_in;
  pad_vec_t i2c_out, i2c_oe, i2c_in, uart_out, uart_oe, uart_in;
  pad_vec_t pad_in, pad_out, pad_oe;

  logic [31:0]  lfsr = 32'hb228_a67a;
  int           cyc;
  int           rsp_errs, pad_errs, func_errs, proto_errs;
  pad_func_e    model_sel [`PAD_NUM_MUXED];
  boot_status_t boot_model;
  reg_data_t    exp_data_q [$];
  logic         exp_err_q [$];
  int           exp_due_q [$];

  always #(CLK_PERIOD / 2) ref_clk = ~ref_clk;

  padframe_top dut0 (
    .ref_clk_i (ref_clk), .rst_n_i (rst_n),
    .boot_mode_i (boot_mode), .secure_boot_i (secure_boot),
    .req_valid_i (req_valid), .req_write_i (req_write),
    .req_addr_i (req_addr), .req_wdata_i (req_wdata),
    .rsp_valid_o (rsp_valid), .rsp_rdata_o (rsp_rdata), .rsp_error_o (rsp_error),
    .gpio_out_i (gpio_out), .gpio_oe_i (gpio_oe), .gpio_in_o (gpio_in),
    .spi_out_i (spi_out), .spi_oe_i (spi_oe), .spi_in_o (spi_in),
    .i2c_out_i (i2c_out), .i2c_oe_i (i2c_oe), .i2c_in_o (i2c_in),
    .uart_out_i (uart_out), .uart_oe_i (uart_oe), .uart_in_o (uart_in),
    .pad_in_i (pad_in), .pad_out_o (pad_out), .pad_oe_o (pad_oe)
  );

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'd0);
    end
    return r;
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_rsp(input reg_data_t got_data, input reg_data_t exp_data,
                           input logic got_err, input logic exp_err);
    if (got_data !== exp_data) begin
      $display("Error rsp_rdata_o exp %h got %h", exp_data, got_data);
      rsp_errs++;
    end
    if (got_err !== exp_err) begin
      $display("Error rsp_error_o exp %h got %h", exp_err, got_err);
      rsp_errs++;
    end
  endtask

  task automatic check_pad(input string name, input pad_vec_t got, input pad_vec_t exp);
    if (got !== exp) begin
      $display("Error %s exp %h got %h", name, exp, got);
      pad_errs++;
    end
  endtask

  task automatic check_func(input string name, input pad_vec_t got, input pad_vec_t exp);
    if (got !== exp) begin
      $display("Error %s exp %h got %h", name, exp, got);
      func_errs++;
    end
  endtask

  //////////////////////////////
  // cycle, request and routing tasks
  //////////////////////////////

  // one clock, then match any response against the queue
  task automatic wait_cycle();
    @(negedge ref_clk);
    cyc++;
    if (exp_due_q.size() != 0 && exp_due_q[0] == cyc) begin
      if (rsp_valid === 1'b1) begin
        check_rsp(rsp_rdata, exp_data_q[0], rsp_error, exp_err_q[0]);
      end else begin
        $display("response due in cycle %0d did not arrive", cyc);
        proto_errs++;
      end
      void'(exp_due_q.pop_front());
      void'(exp_data_q.pop_front());
      void'(exp_err_q.pop_front());
    end else if (rsp_valid !== 1'b0) begin
      $display("response in cycle %0d without a pending request", cyc);
      proto_errs++;
    end
  endtask

  task automatic send_req(input logic wr, input logic [`REG_ADDR_W-1:0] addr,
                          input reg_data_t wdata);
    reg_data_t exp_data;
    logic      exp_err;
    int        idx;
    exp_data = '0;
    exp_err  = 1'b0;
    idx      = int'(addr);
    if (idx < `PAD_NUM_MUXED) begin
      if (wr) begin
        model_sel[idx] = pad_func_e'(wdata[`PAD_FUNC_W-1:0]);
      end else begin
        exp_data = {30'd0, model_sel[idx]};
      end
    end else if (addr == `REG_STATUS_ADDR && !wr) begin
      exp_data = {29'd0, boot_model.secure_boot, boot_model.boot_mode};
    end else begin
      exp_err = 1'b1;
    end
    exp_data_q.push_back(exp_data);
    exp_err_q.push_back(exp_err);
    exp_due_q.push_back(cyc + 2);
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = addr;
    req_wdata = wdata;
    wait_cycle();
    req_valid = 1'b0;
  endtask

  task automatic drain_responses();
    while (exp_due_q.size() != 0) begin
      wait_cycle();
    end
  endtask

  task automatic read_all_pads();
    for (int i = 0; i < `PAD_NUM_MUXED; i++) begin
      send_req(1'b0, `REG_ADDR_W'(i), '0);
    end
  endtask

  task automatic check_routing();
    pad_vec_t own_g, own_s, own_i, own_u;
    pad_vec_t exp_out, exp_oe;
    gpio_out = pad_vec_t'(rand_bits(`PAD_NUM_MUXED));
    gpio_oe  = pad_vec_t'(rand_bits(`PAD_NUM_MUXED));
    spi_out  = pad_vec_t'(rand_bits(`PAD_NUM_MUXED));
    spi_oe   = pad_vec_t'(rand_bits(`PAD_NUM_MUXED));
    i2c_out  = pad_vec_t'(rand_bits(`PAD_NUM_MUXED));
    i2c_oe   = pad_vec_t'(rand_bits(`PAD_NUM_MUXED));
    uart_out = pad_vec_t'(rand_bits(`PAD_NUM_MUXED));
    uart_oe  = pad_vec_t'(rand_bits(`PAD_NUM_MUXED));
    pad_in   = pad_vec_t'(rand_bits(`PAD_NUM_MUXED));
    wait_cycle();
    // ownership masks from the model
    for (int i = 0; i < `PAD_NUM_MUXED; i++) begin
      own_g[i] = (model_sel[i] == FUNC_GPIO);
      own_s[i] = (model_sel[i] == FUNC_SPI);
      own_i[i] = (model_sel[i] == FUNC_I2C);
      own_u[i] = (model_sel[i] == FUNC_UART);
    end
    exp_out = (gpio_out & own_g) | (spi_out & own_s) | (i2c_out & own_i) | (uart_out & own_u);
    exp_oe  = (gpio_oe & own_g) | (spi_oe & own_s) | (i2c_oe & own_i) | (uart_oe & own_u);
    check_pad("pad_out_o", pad_out, exp_out);
    check_pad("pad_oe_o", pad_oe, exp_oe);
    check_func("gpio_in_o", gpio_in, pad_in & own_g);
    check_func("spi_in_o", spi_in, pad_in & own_s);
    check_func("i2c_in_o", i2c_in, pad_in & own_i);
    check_func("uart_in_o", uart_in, pad_in & own_u);
  endtask

  initial begin
    #((NUM_REQ + NUM_ROUTE + 50) * 2 * CLK_PERIOD);
    $display("timeout, the tests did not finish in time");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    logic [`REG_ADDR_W-1:0] addr;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    {gpio_out, gpio_oe, spi_out, spi_oe, i2c_out, i2c_oe} = '0;
    {uart_out, uart_oe, pad_in} = '0;
    boot_mode   = 2'(rand_bits(2));
    secure_boot = (rand_bits(1) != 0);
    boot_model.boot_mode   = boot_mode;
    boot_model.secure_boot = secure_boot;
    for (int i = 0; i < `PAD_NUM_MUXED; i++) begin
      model_sel[i] = FUNC_GPIO;
    end
    repeat (10) wait_cycle();
    rst_n = 1'b1;
    repeat (4) wait_cycle();

    // reset values and gpio routing
    read_all_pads();
    drain_responses();
    check_routing();

    // boot status holds after the pins move
    send_req(1'b0, `REG_STATUS_ADDR, '0);
    boot_mode   = ~boot_model.boot_mode;
    secure_boot = ~boot_model.secure_boot;
    send_req(1'b0, `REG_STATUS_ADDR, '0);
    drain_responses();

    // random writes and reads, mostly back to back
    for (int n = 0; n < 80; n++) begin
      addr = `REG_ADDR_W'(rand_bits(5) % `PAD_NUM_MUXED);
      if (rand_bits(2) == 0) begin
        wait_cycle();
      end else begin
        send_req(rand_bits(1) != 0, addr, rand_bits(32));
      end
    end
    drain_responses();

    // random selects then routing
    for (int r = 0; r < 8; r++) begin
      for (int i = 0; i < `PAD_NUM_MUXED; i++) begin
        send_req(1'b1, `REG_ADDR_W'(i), rand_bits(32));
      end
      drain_responses();
      repeat (4) check_routing();
    end

    // error requests, each followed by a pad read
    for (int n = 0; n < 16; n++) begin
      if (n % 2 == 0) begin
        send_req(1'b1, `REG_STATUS_ADDR, rand_bits(32));
      end else begin
        addr = `REG_ADDR_W'(rand_bits(8));
        if (int'(addr) < `PAD_NUM_MUXED || addr == `REG_STATUS_ADDR) begin
          addr = addr | 8'h40;
        end
        send_req(rand_bits(1) != 0, addr, rand_bits(32));
      end
      send_req(1'b0, `REG_ADDR_W'(rand_bits(5) % `PAD_NUM_MUXED), '0);
    end
    send_req(1'b0, `REG_STATUS_ADDR, '0);
    read_all_pads();
    drain_responses();

    $display("errors: rsp %0d pad %0d func %0d protocol %0d",
             rsp_errs, pad_errs, func_errs, proto_errs);
    if (rsp_errs + pad_errs + func_errs + proto_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
